/* all.f */
design/sv32_pkg.sv
design/tlb_pkg.sv
design/tlb_sram.sv
design/tlb_req_decode.sv
design/tlb_way_array.sv
design/tlb_replace.sv
design/tlb_resp_merge.sv
design/tlb.sv
testbench/tlb_checker.sv
testbench/tb_tlb.sv

/* testbench/tb_tlb.sv */
`timescale 1ns/1ps

module tb_tlb import sv32_pkg::*; ();

    localparam int WAYS      = 4;
    localparam int RESET_CYC = 16;
    localparam int DRAIN     = 2;
    localparam int LEN_RESET = 40;
    localparam int LEN_FILL  = 64;
    localparam int LEN_SPAGE = 1 + 16 * 3;
    localparam int LEN_LRU   = 6 * (2 * WAYS + 6);
    localparam int LEN_MIX   = 400;
    localparam int LIMIT     = RESET_CYC + LEN_RESET + LEN_FILL + LEN_SPAGE + LEN_LRU
                               + LEN_MIX + 5 * DRAIN + 100;

    logic        clk;
    logic        rstn;
    logic        cs;
    logic        we;
    vpn_t        vpn;
    logic        spage_in;
    pte_t        pte_in;
    logic        flush;
    logic        pte_hit;
    logic        spage_out;
    pte_t        pte_out;
    logic        test_end;
    int          test_id;
    int          total_checks;
    int          total_errors;
    int          cycle_cnt;
    logic [31:0] rng;

    tlb #(.WAYS(WAYS)) UUT (.*);

    tlb_checker #(.WAYS(WAYS)) u_check (.*);

    function automatic logic [31:0] rand32();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // Two sets and four upper tags only, so the sets overflow and entries get evicted.
    function automatic vpn_t rand_vpn();
        logic [31:0] r;
        r = rand32();
        return {3'b000, r[1:0], (r[2] ? 5'd6 : 5'd21), (r[5] ? r[15:6] : {8'd0, r[4:3]})};
    endfunction

    task automatic set_inputs(logic c, logic w, vpn_t v, logic s, pte_t p, logic f);
        cs       = c;
        we       = w;
        vpn      = v;
        spage_in = s;
        pte_in   = p;
        flush    = f;
    endtask

    task automatic lookup(vpn_t v);
        @(negedge clk);
        set_inputs(1'b1, 1'b0, v, 1'b0, '0, 1'b0);
    endtask

    task automatic idle();
        @(negedge clk);
        set_inputs(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    // A request presented together with the flush is dropped by the TLB.
    task automatic flush_all(logic c, logic w, vpn_t v);
        @(negedge clk);
        set_inputs(c, w, v, 1'b0, '0, 1'b1);
    endtask

    // Turns into a lookup when the entry would overlap one that the model holds.
    task automatic fill(vpn_t v, logic s);
        pte_t p;
        p = rand32();
        if (s) begin
            p[PPN0_LSB +: VPN0_W] = '0;
        end
        @(negedge clk);
        if (u_check.overlaps(v, s)) begin
            set_inputs(1'b1, 1'b0, v, 1'b0, '0, 1'b0);
        end else begin
            set_inputs(1'b1, 1'b1, v, s, p, 1'b0);
        end
    endtask

    task automatic finish_test();
        idle();
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not end within %0d cycles", LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        vpn_t        v;
        logic [4:0]  set_idx;
        rng      = 32'hd65ef870;
        rstn     = 1'b0;
        test_end = 1'b0;
        test_id  = 0;
        set_inputs(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        v = '0;
        for (int i = 0; i < LEN_RESET; i++) begin
            r = rand32();
            if (i == 30) begin
                flush_all(1'b1, 1'b0, v);    // The last filled entry is looked up as it goes.
            end else if (i >= 8 && i < 30 && r[0]) begin
                v = rand_vpn();
                fill(v, 1'b0);
            end else begin
                lookup(rand_vpn());
            end
        end
        finish_test();

        test_id = 1;
        for (int i = 0; i < LEN_FILL / 2; i++) begin
            v = rand_vpn();
            fill(v, 1'b0);
            lookup(v);
        end
        finish_test();

        test_id = 2;
        flush_all(1'b0, 1'b0, '0);
        for (int i = 0; i < 16; i++) begin
            v = rand_vpn();
            r = rand32();
            fill(v, 1'b1);
            lookup({v[VPN_W-1:VPN0_W], r[VPN0_W-1:0]});
            lookup({v[VPN_W-1:VPN0_W], r[2*VPN0_W-1:VPN0_W]});
        end
        finish_test();

        test_id = 3;
        for (int rnd = 0; rnd < 6; rnd++) begin
            set_idx = 5'(rnd * 5 + 3);
            flush_all(1'b0, 1'b0, '0);
            for (int w = 0; w < WAYS; w++) begin
                fill({5'(w), set_idx, 10'(rnd)}, 1'b0);
            end
            for (int k = 0; k < 3; k++) begin
                r = rand32();
                lookup({5'(r % WAYS), set_idx, 10'(rnd)});
            end
            fill({5'(WAYS), set_idx, 10'(rnd)}, 1'b0);    // One more than the set holds.
            for (int w = 0; w <= WAYS; w++) begin
                lookup({5'(w), set_idx, 10'(rnd)});
            end
        end
        finish_test();

        test_id = 4;
        for (int i = 0; i < LEN_MIX; i++) begin
            r = rand32();
            if (r[4:0] == 0) begin
                flush_all(r[8], r[9], rand_vpn());
            end else if (r[4:0] < 3) begin
                idle();
            end else if (r[4:0] < 16) begin
                lookup(rand_vpn());
            end else begin
                fill(rand_vpn(), r[7:6] == 2'b00);
            end
        end
        finish_test();

        @(posedge clk);
        $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0 && total_checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* testbench/tlb_checker.sv */
`timescale 1ns/1ps

module tlb_checker import sv32_pkg::*, tlb_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic clk,
    input  logic rstn,
    input  logic cs,
    input  logic we,
    input  vpn_t vpn,
    input  logic spage_in,
    input  pte_t pte_in,
    input  logic flush,
    input  logic pte_hit,
    input  logic spage_out,
    input  pte_t pte_out,
    input  int   test_id,
    input  logic test_end,
    output int   total_checks,
    output int   total_errors
);

    logic m_valid [SETS][WAYS];
    logic m_spg   [SETS][WAYS];
    vpn_t m_vpn   [SETS][WAYS];
    pte_t m_pte   [SETS][WAYS];
    int   m_age   [SETS][WAYS];
    logic active;
    logic exp_hit;
    logic exp_spg;
    pte_t exp_pte;
    int   hit_set;
    int   hit_way;
    int   cur_test;
    int   test_checks;
    int   test_errors;

    function automatic string test_name(int id);
        case (id)
            0: return "reset_flush";
            1: return "fill_hit";
            2: return "superpage";
            3: return "lru_eviction";
            default: return "mixed_traffic";
        endcase
    endfunction

    // A superpage entry ignores vpn0, a 4 KiB entry needs the whole VPN.
    function automatic logic covers(int s, int w, vpn_t v);
        if (!m_valid[s][w] || m_vpn[s][w][VPN_W-1:VPN0_W] != v[VPN_W-1:VPN0_W]) begin
            return 1'b0;
        end
        return m_spg[s][w] || (m_vpn[s][w] == v);
    endfunction

    // True when a new entry for v would hit together with an entry already held.
    function automatic logic overlaps(vpn_t v, logic spg);
        int   s;
        logic any;
        s   = int'(v[VPN0_W +: IDX_W]);
        any = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            any |= covers(s, w, v) || (spg && m_valid[s][w]
                   && m_vpn[s][w][VPN_W-1:VPN0_W] == v[VPN_W-1:VPN0_W]);
        end
        return any;
    endfunction

    task automatic reset_model();
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = w;
            end
        end
    endtask

    // The touched way becomes the youngest; the ways younger than it move down by one.
    task automatic touch(int s, int w);
        int old;
        old = m_age[s][w];
        for (int k = 0; k < WAYS; k++) begin
            if (k == w) begin
                m_age[s][k] = WAYS - 1;
            end else if (m_age[s][k] > old) begin
                m_age[s][k]--;
            end
        end
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        test_checks++;
        total_checks++;
        if (expected !== actual) begin
            test_errors++;
            total_errors++;
            $display("Fail %0s: %0s expected %h actual %h at %0t", test_name(cur_test),
                     what, expected, actual, $time);
        end
    endtask

    initial begin
        active       = 1'b0;
        hit_way      = -1;
        cur_test     = 0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
    end

    always @(posedge clk) begin : model_step
        int s;
        int match;
        int found;
        int victim;
        if (!rstn) begin
            reset_model();
            active  = 1'b0;
            hit_way = -1;
        end else begin
            s     = int'(vpn[VPN0_W +: IDX_W]);
            match = -1;
            found = 0;
            if (cs && !we && !flush) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (covers(s, w, vpn)) begin
                        match = w;
                        found++;
                    end
                end
            end
            if (found > 1) begin
                test_errors++;
                total_errors++;
                $display("Error in %0s: VPN %h matches %0d entries of the model",
                         test_name(cur_test), vpn, found);
            end
            exp_hit = (match >= 0);
            exp_spg = 1'b0;
            exp_pte = '0;
            if (match >= 0) begin
                exp_spg = m_spg[s][match];
                exp_pte = m_pte[s][match];
                if (exp_spg) begin
                    exp_pte[PPN0_LSB +: VPN0_W] = vpn[VPN0_W-1:0];    // Offset inside the superpage.
                end
            end
            if (flush) begin
                reset_model();
            end else if (cs && we) begin
                victim = 0;
                for (int w = 0; w < WAYS; w++) begin
                    if (m_age[s][w] == 0) begin
                        victim = w;
                    end
                end
                m_valid[s][victim] = 1'b1;
                m_spg[s][victim]   = spage_in;
                m_vpn[s][victim]   = vpn;
                m_pte[s][victim]   = pte_in;
                touch(s, victim);
            end else if (hit_way >= 0) begin
                touch(hit_set, hit_way);    // Last cycle's hit ages its set now.
            end
            hit_set  = s;
            hit_way  = match;
            cur_test = test_id;
            active   = 1'b1;
            if (test_end) begin
                $display("Test %0s: %0d checks, %0d errors", test_name(cur_test),
                         test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

    always @(negedge clk) begin
        if (active) begin
            check_value("pte_hit", exp_hit, pte_hit);
            check_value("spage_out", exp_spg, spage_out);
            check_value("pte_out", exp_pte, pte_out);
        end
    end

endmodule

/* design/tlb.sv */
`timescale 1ns/1ps

module tlb import sv32_pkg::*, tlb_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic clk,
    input  logic rstn,
    input  logic cs,
    input  logic we,
    input  vpn_t vpn,
    input  logic spage_in,
    input  pte_t pte_in,
    input  logic flush,
    output logic pte_hit,
    output logic spage_out,
    output pte_t pte_out
);

    tlb_req_t        req;
    tlb_look_t       look;
    logic [WAYS-1:0] victim;
    logic [WAYS-1:0] way_hit;
    logic [WAYS-1:0] way_spg;
    pte_t [WAYS-1:0] way_pte;

    tlb_req_decode u_decode (
        .clk      (clk),
        .rstn     (rstn),
        .cs       (cs),
        .we       (we),
        .vpn      (vpn),
        .spage_in (spage_in),
        .flush    (flush),
        .req      (req),
        .look     (look)
    );

    tlb_way_array #(
        .WAYS (WAYS)
    ) u_ways (
        .clk      (clk),
        .rstn     (rstn),
        .cs       (cs),
        .we       (we),
        .spage_in (spage_in),
        .flush    (flush),
        .req      (req),
        .look     (look),
        .victim   (victim),
        .pte_in   (pte_in),
        .way_hit  (way_hit),
        .way_spg  (way_spg),
        .way_pte  (way_pte)
    );

    tlb_replace #(
        .WAYS (WAYS)
    ) u_replace (
        .clk     (clk),
        .rstn    (rstn),
        .cs      (cs),
        .we      (we),
        .flush   (flush),
        .req     (req),
        .look    (look),
        .way_hit (way_hit),
        .victim  (victim)
    );

    tlb_resp_merge #(
        .WAYS (WAYS)
    ) u_merge (
        .look      (look),
        .way_hit   (way_hit),
        .way_spg   (way_spg),
        .way_pte   (way_pte),
        .pte_hit   (pte_hit),
        .spage_out (spage_out),
        .pte_out   (pte_out)
    );

endmodule

/* design/tlb_resp_merge.sv */
`timescale 1ns/1ps

module tlb_resp_merge import sv32_pkg::*, tlb_pkg::*; #(
    parameter int WAYS = 4
) (
    input  tlb_look_t       look,
    input  logic [WAYS-1:0] way_hit,
    input  logic [WAYS-1:0] way_spg,
    input  pte_t [WAYS-1:0] way_pte,
    output logic            pte_hit,
    output logic            spage_out,
    output pte_t            pte_out
);

    pte_t hit_pte;
    pte_t spg_ppn0;

    assign pte_hit   = |way_hit;
    assign spage_out = |(way_hit & way_spg);

    // At most one way hits, so an OR acts as the select.
    always_comb begin
        hit_pte = '0;
        for (int g = 0; g < WAYS; g++) begin
            hit_pte |= way_pte[g] & {PTE_W{way_hit[g]}};
        end
    end

    assign spg_ppn0 = pte_t'(look.vpn0) << PPN0_LSB;    // Page offset bits of a superpage.
    assign pte_out  = spage_out ? (hit_pte | spg_ppn0) : hit_pte;

endmodule

/* design/tlb_replace.sv */
`timescale 1ns/1ps

module tlb_replace import tlb_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            cs,
    input  logic            we,
    input  logic            flush,
    input  tlb_req_t        req,
    input  tlb_look_t       look,
    input  logic [WAYS-1:0] way_hit,
    output logic [WAYS-1:0] victim
);

    localparam int AGE_W = $clog2(WAYS);

    typedef logic [WAYS-1:0][AGE_W-1:0] age_row_t;

    function automatic age_row_t reset_ages();
        age_row_t row;
        for (int g = 0; g < WAYS; g++) begin
            row[g] = AGE_W'(g);
        end
        return row;
    endfunction

    localparam age_row_t AGE_INIT = reset_ages();

    age_row_t         ages [SETS];
    age_row_t         req_ages;
    age_row_t         look_ages;
    age_row_t         fill_row;
    age_row_t         hit_row;
    logic [AGE_W-1:0] hit_age;
    logic             fill;
    logic             hit;

    assign fill      = cs && we;
    assign hit       = |way_hit && !fill;    // A fill right after a lookup takes the update slot.
    assign req_ages  = ages[req.idx];
    assign look_ages = ages[look.idx];

    always_comb begin
        for (int g = 0; g < WAYS; g++) begin
            victim[g] = (req_ages[g] == '0);
        end
    end

    always_comb begin
        hit_age = '0;
        for (int g = 0; g < WAYS; g++) begin
            hit_age |= look_ages[g] & {AGE_W{way_hit[g]}};
        end
    end

    // The victim is always age 0, so every other way moves down by one.
    always_comb begin
        for (int g = 0; g < WAYS; g++) begin
            if (victim[g]) begin
                fill_row[g] = AGE_W'(WAYS - 1);
            end else begin
                fill_row[g] = req_ages[g] - 1'b1;
            end
        end
    end

    always_comb begin
        for (int g = 0; g < WAYS; g++) begin
            if (way_hit[g]) begin
                hit_row[g] = AGE_W'(WAYS - 1);
            end else if (look_ages[g] > hit_age) begin
                hit_row[g] = look_ages[g] - 1'b1;
            end else begin
                hit_row[g] = look_ages[g];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                ages[s] <= AGE_INIT;
            end
        end else if (flush) begin
            for (int s = 0; s < SETS; s++) begin
                ages[s] <= AGE_INIT;
            end
        end else if (fill) begin
            ages[req.idx] <= fill_row;
        end else if (hit) begin
            ages[look.idx] <= hit_row;
        end
    end

    for (genvar s = 0; s < SETS; s++) begin : g_perm
        logic [WAYS-1:0] seen;

        always_comb begin
            seen = '0;
            for (int g = 0; g < WAYS; g++) begin
                seen[ages[s][g]] = 1'b1;
            end
        end

        a_age_perm: assert property (@(posedge clk) disable iff (!rstn) &seen)
            else $error("Ages of set %0d are not a permutation.", s);
    end

    a_victim_onehot: assert property (@(posedge clk) disable iff (!rstn)
                                      fill |-> $onehot(victim))
        else $error("Fill without a single victim way.");

endmodule

/* design/tlb_way_array.sv */
`timescale 1ns/1ps

module tlb_way_array import sv32_pkg::*, tlb_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            cs,
    input  logic            we,
    input  logic            spage_in,
    input  logic            flush,
    input  tlb_req_t        req,
    input  tlb_look_t       look,
    input  logic [WAYS-1:0] victim,
    input  pte_t            pte_in,
    output logic [WAYS-1:0] way_hit,
    output logic [WAYS-1:0] way_spg,
    output pte_t [WAYS-1:0] way_pte
);

    logic fill;

    assign fill = cs && we && !flush;    // Flush wins over a fill in the same cycle.

    for (genvar g = 0; g < WAYS; g++) begin : g_way
        logic [SETS-1:0] valid;
        logic [SETS-1:0] spg;
        logic            valid_q;
        logic            spg_q;
        logic            ram_we;
        tag_t            tag_out;
        tag_t            tag_cmp;

        assign ram_we = fill && victim[g];

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid <= '0;
                spg   <= '0;
            end else if (flush) begin
                valid <= '0;
            end else if (ram_we) begin
                valid[req.idx] <= 1'b1;
                spg[req.idx]   <= spage_in;
            end
        end

        // Captured on the same edge as the RAM read.
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= 1'b0;
                spg_q   <= 1'b0;
            end else if (cs) begin
                valid_q <= valid[req.idx];
                spg_q   <= spg[req.idx];
            end
        end

        assign tag_cmp    = {look.tag[TAG_W-1:VPN0_W],
                             look.tag[VPN0_W-1:0] & {VPN0_W{~spg_q}}};
        assign way_hit[g] = look.lookup && valid_q && (tag_out == tag_cmp);
        assign way_spg[g] = spg_q;

        tlb_sram #(
            .DEPTH_W (IDX_W),
            .DATA_W  (TAG_W)
        ) u_tag_ram (
            .clk  (clk),
            .cs   (cs),
            .we   (ram_we),
            .addr (req.idx),
            .din  (req.tag),
            .dout (tag_out)
        );

        tlb_sram #(
            .DEPTH_W (IDX_W),
            .DATA_W  (PTE_W)
        ) u_pte_ram (
            .clk  (clk),
            .cs   (cs),
            .we   (ram_we),
            .addr (req.idx),
            .din  (pte_in),
            .dout (way_pte[g])
        );
    end

    // Holds only as long as no VPN is filled twice.
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(way_hit))
        else $error("Lookup hit in more than one way.");

endmodule

/* design/tlb_req_decode.sv */
`timescale 1ns/1ps

module tlb_req_decode import sv32_pkg::*, tlb_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      cs,
    input  logic      we,
    input  vpn_t      vpn,
    input  logic      spage_in,
    input  logic      flush,
    output tlb_req_t  req,
    output tlb_look_t look
);

    localparam int HI_W = VPN_W - VPN0_W - IDX_W;

    logic            fill_spg;
    logic [HI_W-1:0] vpn_hi;
    vpn0_t           vpn0;

    assign vpn0     = vpn[VPN0_W-1:0];
    assign vpn_hi   = vpn[VPN_W-1:VPN0_W+IDX_W];
    assign fill_spg = cs && we && spage_in;    // Only a superpage fill stores a masked tag.

    assign req.idx  = vpn[VPN0_W +: IDX_W];
    assign req.tag  = {vpn_hi, vpn0 & {VPN0_W{~fill_spg}}};
    assign req.vpn0 = vpn0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            look <= '0;
        end else begin
            look.lookup <= cs && !we && !flush;    // A flush kills a lookup of the same cycle.
            look.idx    <= req.idx;
            look.tag    <= req.tag;
            look.vpn0   <= req.vpn0;
        end
    end

endmodule

/* design/tlb_sram.sv */
`timescale 1ns/1ps

module tlb_sram #(
    parameter int DEPTH_W = 5,
    parameter int DATA_W  = 32
) (
    input  logic               clk,
    input  logic               cs,
    input  logic               we,
    input  logic [DEPTH_W-1:0] addr,
    input  logic [DATA_W-1:0]  din,
    output logic [DATA_W-1:0]  dout
);

    logic [DATA_W-1:0] mem [1 << DEPTH_W];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];    // Read before write, so a fill returns the old entry.
        end
    end

endmodule

/* design/tlb_pkg.sv */
package tlb_pkg;

    import sv32_pkg::*;

    localparam int IDX_W = 5;
    localparam int SETS  = 1 << IDX_W;
    localparam int TAG_W = VPN_W - IDX_W;    // Upper VPN bits plus vpn0.

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // Address fields of the request presented this cycle.
    typedef struct packed {
        idx_t  idx;
        tag_t  tag;
        vpn0_t vpn0;
    } tlb_req_t;

    // Context of last cycle's lookup.
    typedef struct packed {
        logic  lookup;
        idx_t  idx;
        tag_t  tag;
        vpn0_t vpn0;
    } tlb_look_t;

endpackage

/* design/sv32_pkg.sv */
package sv32_pkg;

    localparam int VPN_W    = 20;
    localparam int VPN0_W   = 10;
    localparam int PTE_W    = 32;
    localparam int PPN0_LSB = 10;     // The low PPN field sits just above the flag bits.

    // Virtual page number of an Sv32 address, without the page offset.
    typedef logic [VPN_W-1:0] vpn_t;

    // Low VPN field that indexes within a 4 MiB superpage.
    typedef logic [VPN0_W-1:0] vpn0_t;

    // The PPN occupies bits 31 to 10 and the flags occupy bits 9 to 0.
    typedef logic [PTE_W-1:0] pte_t;

endpackage
